//--- run.sh
#!/bin/sh
# Build and run the SoC interface testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module soc_ifc_tb -o sim_soc_ifc
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_soc_ifc 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "PASS: all tests"; then
    exit 0
fi
exit 1

//--- source/boot_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Boot sequencer
// Releases the non-core reset once fuses are done, then the uC reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module boot_fsm #(
    parameter int UC_RST_WAIT = 8
) (
    input  logic clk,
    input  logic cptra_rst_b,
    input  logic fuse_done_i,
    output logic ready_for_fuses_o,
    output logic noncore_rst_b_o,
    output logic uc_rst_b_o
);

    localparam logic [7:0] WAIT_LAST = 8'(UC_RST_WAIT - 1);

    soc_ifc_boot_pkg::boot_state_e state_q;
    soc_ifc_boot_pkg::boot_state_e state_d;
    logic [7:0]                    cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            soc_ifc_boot_pkg::BOOT_IDLE: state_d = soc_ifc_boot_pkg::BOOT_FUSE;
            soc_ifc_boot_pkg::BOOT_FUSE:
                if (fuse_done_i) state_d = soc_ifc_boot_pkg::BOOT_WAIT;
            soc_ifc_boot_pkg::BOOT_WAIT:
                if (cnt_q == WAIT_LAST) state_d = soc_ifc_boot_pkg::BOOT_DONE;
            default: state_d = soc_ifc_boot_pkg::BOOT_DONE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////////
    // State, wait counter and registered reset outputs
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_q           <= soc_ifc_boot_pkg::BOOT_IDLE;
            cnt_q             <= '0;
            ready_for_fuses_o <= 1'b0;
            noncore_rst_b_o   <= 1'b0;
            uc_rst_b_o        <= 1'b0;
        end else begin
            state_q <= state_d;
            // Count only while the uC is still held in reset
            if (state_q == soc_ifc_boot_pkg::BOOT_WAIT) begin
                cnt_q <= cnt_q + 8'd1;
            end else begin
                cnt_q <= '0;
            end
            ready_for_fuses_o <= (state_d != soc_ifc_boot_pkg::BOOT_IDLE);
            noncore_rst_b_o   <= (state_d == soc_ifc_boot_pkg::BOOT_WAIT) ||
                                 (state_d == soc_ifc_boot_pkg::BOOT_DONE);
            uc_rst_b_o        <= (state_d == soc_ifc_boot_pkg::BOOT_DONE);
        end
    end

    // The uC must never run ahead of the blocks around it
    rst_order_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        uc_rst_b_o |-> noncore_rst_b_o);

endmodule

//--- source/fuse_regs.sv
////////////////////////////////////////////////////////////////////////////
// Fuse register bank
// Fuse words plus a sticky write-done bit that locks the whole bank
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fuse_regs #(
    parameter int NUM_FUSE_WORDS = 8
) (
    input  logic                                    clk,
    input  logic                                    cptra_rst_b,
    input  logic                                    sel_i,
    input  logic [soc_ifc_map_pkg::REG_IDX_W-1:0]   reg_idx_i,
    input  logic                                    write_i,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]      wdata_i,
    output logic [soc_ifc_map_pkg::DATA_W-1:0]      rdata_o,
    output logic                                    hit_o,
    output logic                                    fuse_done_o
);

    logic [NUM_FUSE_WORDS-1:0][soc_ifc_map_pkg::DATA_W-1:0] fuse_q;
    logic                                                    done_q;
    logic                                                    wr_en;

    // Nothing in the bank changes once done is set
    assign wr_en = sel_i && write_i && !done_q;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_q <= '0;
            done_q <= 1'b0;
        end else if (wr_en) begin
            for (int i = 0; i < NUM_FUSE_WORDS; i++) begin
                if (reg_idx_i == soc_ifc_map_pkg::REG_IDX_W'(i)) begin
                    fuse_q[i] <= wdata_i;
                end
            end
            if (reg_idx_i == soc_ifc_map_pkg::IDX_FUSE_DONE) begin
                done_q <= wdata_i[0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b0;
        for (int i = 0; i < NUM_FUSE_WORDS; i++) begin
            if (reg_idx_i == soc_ifc_map_pkg::REG_IDX_W'(i)) begin
                rdata_o = fuse_q[i];
                hit_o   = 1'b1;
            end
        end
        if (reg_idx_i == soc_ifc_map_pkg::IDX_FUSE_DONE) begin
            rdata_o = {{(soc_ifc_map_pkg::DATA_W-1){1'b0}}, done_q};
            hit_o   = 1'b1;
        end
    end

    assign fuse_done_o = done_q;

    // The boot sequence relies on done being sticky
    fuse_done_sticky_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        !$fell(fuse_done_o));

endmodule

//--- source/soc_ifc_boot_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Boot sequencer definitions
////////////////////////////////////////////////////////////////////////////

package soc_ifc_boot_pkg;

    // Reset release sequence
    typedef enum logic [1:0] {
        BOOT_IDLE = 2'd0,
        BOOT_FUSE = 2'd1,
        BOOT_WAIT = 2'd2,
        BOOT_DONE = 2'd3
    } boot_state_e;

    // Cycles between non-core and microcontroller reset release
    localparam int UC_RST_WAIT_DEF = 8;

endpackage

//--- source/soc_ifc_map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// SoC interface register map
// Bus widths, the two-bank address layout and response error codes
////////////////////////////////////////////////////////////////////////////

package soc_ifc_map_pkg;

    // Request bus widths
    localparam int ADDR_W    = 6;
    localparam int DATA_W    = 32;
    localparam int USER_W    = 8;
    localparam int REG_IDX_W = 5;

    // Request address, seen either as a word offset or as bank plus index
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic                 bank_sel;
            logic [REG_IDX_W-1:0] reg_idx;
        } fields;
    } soc_addr_u;

    // Bank select encoding
    localparam logic BANK_FUSE = 1'b0;
    localparam logic BANK_TRNG = 1'b1;

    // Fuse bank control register
    localparam logic [REG_IDX_W-1:0] IDX_FUSE_DONE = 5'd16;

    // TRNG bank control registers
    localparam logic [REG_IDX_W-1:0] IDX_TRNG_VALID_USER = 5'd16;
    localparam logic [REG_IDX_W-1:0] IDX_TRNG_USER_LOCK  = 5'd17;
    localparam logic [REG_IDX_W-1:0] IDX_TRNG_STATUS     = 5'd18;

    // Response error codes
    localparam logic ERR_NONE   = 1'b0;
    localparam logic ERR_DECODE = 1'b1;

endpackage

//--- source/soc_ifc_top.sv
////////////////////////////////////////////////////////////////////////////
// SoC interface top level
// Request slave, fuse and TRNG register banks and the boot sequencer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module soc_ifc_top #(
    parameter int NUM_FUSE_WORDS = 8,
    parameter int NUM_TRNG_WORDS = 4,
    parameter int UC_RST_WAIT    = soc_ifc_boot_pkg::UC_RST_WAIT_DEF
) (
    input  logic                                clk,
    input  logic                                cptra_rst_b,
    input  logic                                req_i,
    input  logic                                write_i,
    input  soc_ifc_map_pkg::soc_addr_u          addr_i,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]  wdata_i,
    input  logic [soc_ifc_map_pkg::USER_W-1:0]  user_i,
    output logic                                ack_o,
    output logic [soc_ifc_map_pkg::DATA_W-1:0]  rdata_o,
    output logic                                err_o,
    output logic                                ready_for_fuses_o,
    output logic                                noncore_rst_b_o,
    output logic                                uc_rst_b_o,
    output logic                                fuse_done_o,
    output logic                                trng_done_o
);

    // Shared request bus towards both banks
    logic                                     fuse_sel;
    logic                                     trng_sel;
    logic [soc_ifc_map_pkg::REG_IDX_W-1:0]    reg_idx;
    logic                                     bank_write;
    logic [soc_ifc_map_pkg::DATA_W-1:0]       bank_wdata;
    logic [soc_ifc_map_pkg::USER_W-1:0]       bank_user;
    logic [soc_ifc_map_pkg::DATA_W-1:0]       fuse_rdata;
    logic [soc_ifc_map_pkg::DATA_W-1:0]       trng_rdata;
    logic                                     fuse_hit;
    logic                                     trng_hit;

    soc_req_slave u_req_slave (
        .clk, .cptra_rst_b,
        .req_i, .write_i, .addr_i, .wdata_i, .user_i,
        .ack_o, .rdata_o, .err_o,
        .fuse_sel_o (fuse_sel),   .trng_sel_o (trng_sel),
        .reg_idx_o  (reg_idx),    .write_o    (bank_write),
        .wdata_o    (bank_wdata), .user_o     (bank_user),
        .fuse_rdata_i (fuse_rdata), .fuse_hit_i (fuse_hit),
        .trng_rdata_i (trng_rdata), .trng_hit_i (trng_hit)
    );

    fuse_regs #(.NUM_FUSE_WORDS(NUM_FUSE_WORDS)) u_fuse_regs (
        .clk, .cptra_rst_b,
        .sel_i (fuse_sel), .reg_idx_i (reg_idx), .write_i (bank_write),
        .wdata_i (bank_wdata), .rdata_o (fuse_rdata), .hit_o (fuse_hit),
        .fuse_done_o
    );

    trng_regs #(.NUM_TRNG_WORDS(NUM_TRNG_WORDS)) u_trng_regs (
        .clk, .cptra_rst_b,
        .sel_i (trng_sel), .reg_idx_i (reg_idx), .write_i (bank_write),
        .wdata_i (bank_wdata), .user_i (bank_user),
        .rdata_o (trng_rdata), .hit_o (trng_hit), .trng_done_o
    );

    boot_fsm #(.UC_RST_WAIT(UC_RST_WAIT)) u_boot_fsm (
        .clk, .cptra_rst_b,
        .fuse_done_i (fuse_done_o),
        .ready_for_fuses_o, .noncore_rst_b_o, .uc_rst_b_o
    );

endmodule

//--- source/soc_req_slave.sv
////////////////////////////////////////////////////////////////////////////
// SoC request slave
// Runs the req/ack handshake, routes each request to one register bank
// and registers the combined read data and error
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module soc_req_slave (
    input  logic                                    clk,
    input  logic                                    cptra_rst_b,
    input  logic                                    req_i,
    input  logic                                    write_i,
    input  soc_ifc_map_pkg::soc_addr_u              addr_i,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]      wdata_i,
    input  logic [soc_ifc_map_pkg::USER_W-1:0]      user_i,
    output logic                                    ack_o,
    output logic [soc_ifc_map_pkg::DATA_W-1:0]      rdata_o,
    output logic                                    err_o,
    output logic                                    fuse_sel_o,
    output logic                                    trng_sel_o,
    output logic [soc_ifc_map_pkg::REG_IDX_W-1:0]   reg_idx_o,
    output logic                                    write_o,
    output logic [soc_ifc_map_pkg::DATA_W-1:0]      wdata_o,
    output logic [soc_ifc_map_pkg::USER_W-1:0]      user_o,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]      fuse_rdata_i,
    input  logic                                    fuse_hit_i,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]      trng_rdata_i,
    input  logic                                    trng_hit_i
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_SEL  = 3'd1;
    localparam logic [2:0] ST_RESP = 3'd2;
    localparam logic [2:0] ST_ACK  = 3'd3;
    localparam logic [2:0] ST_DROP = 3'd4;

    logic [2:0]                 state_q;
    logic [2:0]                 state_d;
    soc_ifc_map_pkg::soc_addr_u req_addr_q;
    logic                       bank_hit;

    //////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (req_i) state_d = ST_SEL;
            ST_SEL:  state_d = ST_RESP;
            ST_RESP: state_d = ST_ACK;
            // Master may hold req high as long as it likes
            ST_ACK:  if (!req_i) state_d = ST_DROP;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_q <= ST_IDLE;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_o   <= (state_d == ST_ACK) || (state_d == ST_DROP);
            if (state_q == ST_SEL) begin
                err_o <= bank_hit ? soc_ifc_map_pkg::ERR_NONE : soc_ifc_map_pkg::ERR_DECODE;
            end
        end
    end

    // Request payload is captured once when the request is accepted
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_i) begin
            req_addr_q.raw <= addr_i.raw;
            write_o        <= write_i;
            wdata_o        <= wdata_i;
            user_o         <= user_i;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Bank decode and response merge
    //////////////////////////////////////////////////////////////////////////
    assign reg_idx_o  = req_addr_q.fields.reg_idx;
    assign fuse_sel_o = (state_q == ST_SEL) &&
                        (req_addr_q.fields.bank_sel == soc_ifc_map_pkg::BANK_FUSE);
    assign trng_sel_o = (state_q == ST_SEL) &&
                        (req_addr_q.fields.bank_sel == soc_ifc_map_pkg::BANK_TRNG);
    assign bank_hit   = req_addr_q.fields.bank_sel ? trng_hit_i : fuse_hit_i;

    always_ff @(posedge clk) begin
        if (state_q == ST_SEL) begin
            rdata_o <= req_addr_q.fields.bank_sel ? trng_rdata_i : fuse_rdata_i;
        end
    end

    // Ack only answers a request that is still being held
    ack_needs_req_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $rose(ack_o) |-> $past(req_i));

    sel_onehot_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $onehot0({fuse_sel_o, trng_sel_o}));

endmodule

//--- source/trng_regs.sv
////////////////////////////////////////////////////////////////////////////
// TRNG register bank
// Entropy data words, writable only by the lockable valid user ID
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module trng_regs #(
    parameter int NUM_TRNG_WORDS = 4
) (
    input  logic                                    clk,
    input  logic                                    cptra_rst_b,
    input  logic                                    sel_i,
    input  logic [soc_ifc_map_pkg::REG_IDX_W-1:0]   reg_idx_i,
    input  logic                                    write_i,
    input  logic [soc_ifc_map_pkg::DATA_W-1:0]      wdata_i,
    input  logic [soc_ifc_map_pkg::USER_W-1:0]      user_i,
    output logic [soc_ifc_map_pkg::DATA_W-1:0]      rdata_o,
    output logic                                    hit_o,
    output logic                                    trng_done_o
);

    localparam int PAD_W = soc_ifc_map_pkg::DATA_W - soc_ifc_map_pkg::USER_W;

    logic [NUM_TRNG_WORDS-1:0][soc_ifc_map_pkg::DATA_W-1:0] data_q;
    logic [soc_ifc_map_pkg::USER_W-1:0]                      valid_user_q;
    logic                                                    lock_q;
    logic                                                    done_q;
    logic                                                    wr_en;
    logic                                                    user_ok;

    assign wr_en   = sel_i && write_i;
    assign user_ok = (user_i == valid_user_q);

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            data_q       <= '0;
            valid_user_q <= '0;
            lock_q       <= 1'b0;
            done_q       <= 1'b0;
        end else if (wr_en) begin
            // Foreign users are dropped without an error
            for (int i = 0; i < NUM_TRNG_WORDS; i++) begin
                if (user_ok && reg_idx_i == soc_ifc_map_pkg::REG_IDX_W'(i)) begin
                    data_q[i] <= wdata_i;
                end
            end
            case (reg_idx_i)
                soc_ifc_map_pkg::IDX_TRNG_VALID_USER:
                    if (!lock_q) valid_user_q <= wdata_i[soc_ifc_map_pkg::USER_W-1:0];
                soc_ifc_map_pkg::IDX_TRNG_USER_LOCK:
                    lock_q <= lock_q | wdata_i[0];
                soc_ifc_map_pkg::IDX_TRNG_STATUS:
                    if (user_ok) done_q <= wdata_i[0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////////////////////////////
    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b1;
        case (reg_idx_i)
            soc_ifc_map_pkg::IDX_TRNG_VALID_USER: rdata_o = {{PAD_W{1'b0}}, valid_user_q};
            soc_ifc_map_pkg::IDX_TRNG_USER_LOCK:  rdata_o[0] = lock_q;
            soc_ifc_map_pkg::IDX_TRNG_STATUS:     rdata_o[0] = done_q;
            default:                              hit_o = 1'b0;
        endcase
        for (int i = 0; i < NUM_TRNG_WORDS; i++) begin
            if (reg_idx_i == soc_ifc_map_pkg::REG_IDX_W'(i)) begin
                rdata_o = data_q[i];
                hit_o   = 1'b1;
            end
        end
    end

    assign trng_done_o = done_q;

    valid_user_locked_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        lock_q |=> $stable(valid_user_q));

endmodule

//--- tests/soc_ifc_tb.sv
////////////////////////////////////////////////////////////////////////////
// SoC interface testbench
// Drives register accesses and checks handshake, locking and boot rules
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module soc_ifc_tb;

    localparam int NUM_FUSE = 8;
    localparam int NUM_TRNG = 4;
    localparam int UC_WAIT  = 8;
    localparam int TIMEOUT  = 100;

    logic                              clk;
    logic                              cptra_rst_b;
    logic                              req_i;
    logic                              write_i;
    soc_ifc_map_pkg::soc_addr_u        addr_i;
    logic [31:0]                       wdata_i;
    logic [7:0]                        user_i;
    logic                              ack_o;
    logic [31:0]                       rdata_o;
    logic                              err_o;
    logic                              ready_for_fuses_o;
    logic                              noncore_rst_b_o;
    logic                              uc_rst_b_o;
    logic                              fuse_done_o;
    logic                              trng_done_o;

    // Reference model of the register banks
    logic [31:0] m_fuse [NUM_FUSE];
    logic        m_fuse_done;
    logic [31:0] m_trng [NUM_TRNG];
    logic [7:0]  m_valid_user;
    logic        m_lock;
    logic        m_trng_done;

    // Cycle counters seen by the timing assertions
    int req_high_cycles;
    int req_low_cycles;
    int done_cycles;
    int noncore_cycles;

    tb_clk_gen u_clk_gen (.clk(clk), .cptra_rst_b(cptra_rst_b));

    soc_ifc_top #(
        .NUM_FUSE_WORDS(NUM_FUSE),
        .NUM_TRNG_WORDS(NUM_TRNG),
        .UC_RST_WAIT(UC_WAIT)
    ) dut_i (
        .clk, .cptra_rst_b, .req_i, .write_i, .addr_i, .wdata_i, .user_i,
        .ack_o, .rdata_o, .err_o, .ready_for_fuses_o, .noncore_rst_b_o,
        .uc_rst_b_o, .fuse_done_o, .trng_done_o
    );

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("Error %s: expected %h actual %h", name, exp, act);
        stop_with_failure();
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    always @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            req_high_cycles <= 0;
            req_low_cycles  <= 0;
            done_cycles     <= 0;
            noncore_cycles  <= 0;
        end else begin
            req_high_cycles <= req_i ? req_high_cycles + 1 : 0;
            req_low_cycles  <= req_i ? 0 : req_low_cycles + 1;
            done_cycles     <= fuse_done_o ? done_cycles + 1 : 0;
            noncore_cycles  <= noncore_rst_b_o ? noncore_cycles + 1 : 0;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Timing checks
    //////////////////////////////////////////////////////////////////////////
    // Outputs change just after an edge and are sampled one edge later
    ack_rise_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $rose(ack_o) |-> req_high_cycles == 3)
        else report_problem("ack_o did not rise 2 cycles after req_i was sampled high");

    ack_fall_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $fell(ack_o) |-> req_low_cycles == 2)
        else report_problem("ack_o did not fall 1 cycle after req_i was sampled low");

    fuse_done_hold_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        !$fell(fuse_done_o))
        else report_problem("fuse_done_o fell while out of reset");

    ready_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $past(cptra_rst_b) |-> ready_for_fuses_o)
        else report_problem("ready_for_fuses_o was not high after reset");

    noncore_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $rose(noncore_rst_b_o) |-> done_cycles == 1)
        else report_problem("noncore_rst_b_o did not rise 1 cycle after fuse_done_o");

    uc_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        $rose(uc_rst_b_o) |-> noncore_cycles == UC_WAIT)
        else report_problem("uc_rst_b_o did not rise UC_RST_WAIT cycles after noncore");

    //////////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////////
    function automatic soc_ifc_map_pkg::soc_addr_u make_addr(logic bank, int idx);
        soc_ifc_map_pkg::soc_addr_u a;
        a.fields.bank_sel = bank;
        a.fields.reg_idx  = 5'(idx);
        return a;
    endfunction

    function automatic void model_write(soc_ifc_map_pkg::soc_addr_u a, logic [31:0] d,
                                        logic [7:0] u);
        int idx;
        idx = int'(a.fields.reg_idx);
        if (a.fields.bank_sel == 1'b0) begin
            if (!m_fuse_done && idx < NUM_FUSE) m_fuse[idx] = d;
            else if (!m_fuse_done && idx == 16) m_fuse_done = d[0];
        end else begin
            if (idx < NUM_TRNG && u == m_valid_user) m_trng[idx] = d;
            else if (idx == 16 && !m_lock) m_valid_user = d[7:0];
            else if (idx == 17) m_lock = m_lock | d[0];
            else if (idx == 18 && u == m_valid_user) m_trng_done = d[0];
        end
    endfunction

    function automatic void model_read(soc_ifc_map_pkg::soc_addr_u a, output logic [31:0] d,
                                       output logic e);
        int idx;
        idx = int'(a.fields.reg_idx);
        d = '0;
        e = 1'b0;
        if (a.fields.bank_sel == 1'b0) begin
            if (idx < NUM_FUSE) d = m_fuse[idx];
            else if (idx == 16) d = {31'd0, m_fuse_done};
            else e = 1'b1;
        end else begin
            if (idx < NUM_TRNG) d = m_trng[idx];
            else if (idx == 16) d = {24'd0, m_valid_user};
            else if (idx == 17) d = {31'd0, m_lock};
            else if (idx == 18) d = {31'd0, m_trng_done};
            else e = 1'b1;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////////////////////////////
    task automatic bus_access(input logic wr, input soc_ifc_map_pkg::soc_addr_u a,
                              input logic [31:0] d, input logic [7:0] u, input int hold,
                              output logic [31:0] rd, output logic e);
        int cnt;
        @(posedge clk);
        #1;
        req_i   = 1'b1;
        write_i = wr;
        addr_i  = a;
        wdata_i = d;
        user_i  = u;
        cnt = 0;
        do begin
            @(posedge clk);
            #1;
            cnt++;
        end while (!ack_o && cnt < TIMEOUT);
        if (!ack_o) report_problem("Timeout waiting for ack_o to rise");
        rd = rdata_o;
        e  = err_o;
        // Back-pressure keeps ack high
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        req_i = 1'b0;
        cnt = 0;
        do begin
            @(posedge clk);
            #1;
            cnt++;
        end while (ack_o && cnt < TIMEOUT);
        if (ack_o) report_problem("Timeout waiting for ack_o to fall");
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    task automatic write_reg(string name, soc_ifc_map_pkg::soc_addr_u a, logic [31:0] d,
                             logic [7:0] u);
        logic [31:0] rd;
        logic        e;
        logic [31:0] exp_d;
        logic        exp_e;
        model_read(a, exp_d, exp_e);
        bus_access(1'b1, a, d, u, 0, rd, e);
        check_value({name, " err"}, {31'd0, exp_e}, {31'd0, e});
        model_write(a, d, u);
    endtask

    task automatic read_check(string name, soc_ifc_map_pkg::soc_addr_u a, int hold);
        logic [31:0] rd;
        logic        e;
        logic [31:0] exp_d;
        logic        exp_e;
        model_read(a, exp_d, exp_e);
        bus_access(1'b0, a, '0, 8'h00, hold, rd, e);
        check_value({name, " err"}, {31'd0, exp_e}, {31'd0, e});
        if (!exp_e) check_value({name, " data"}, exp_d, rd);
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////////
    initial begin
        int cnt;
        void'($urandom(36360));
        req_i = 1'b0;
        write_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        user_i = '0;
        m_fuse = '{default: '0};
        m_trng = '{default: '0};
        m_fuse_done = 1'b0;
        m_valid_user = '0;
        m_lock = 1'b0;
        m_trng_done = 1'b0;

        #3;
        check_value("reset ack", 32'd0, {31'd0, ack_o});
        check_value("reset err", 32'd0, {31'd0, err_o});
        check_value("reset ready", 32'd0, {31'd0, ready_for_fuses_o});
        check_value("reset noncore", 32'd0, {31'd0, noncore_rst_b_o});
        check_value("reset uc", 32'd0, {31'd0, uc_rst_b_o});
        cnt = 0;
        while (!cptra_rst_b && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!cptra_rst_b) report_problem("Timeout waiting for reset release");
        repeat (2) @(posedge clk);

        // Fuse words read back, then lock the bank
        for (int i = 0; i < NUM_FUSE; i++)
            write_reg("fuse write", make_addr(0, i), $urandom, 8'h01);
        for (int i = 0; i < NUM_FUSE; i++) read_check("fuse read", make_addr(0, i), i % 3);
        read_check("fuse unmapped", make_addr(0, 20), 0);
        read_check("fuse done clear", make_addr(0, 16), 0);
        write_reg("fuse done set", make_addr(0, 16), 32'd1, 8'h01);
        for (int i = 0; i < NUM_FUSE; i++)
            write_reg("fuse locked", make_addr(0, i), $urandom, 8'h01);
        write_reg("fuse done clear try", make_addr(0, 16), 32'd0, 8'h01);
        for (int i = 0; i < NUM_FUSE; i++) read_check("fuse after lock", make_addr(0, i), 0);
        check_value("fuse_done_o", 32'd1, {31'd0, fuse_done_o});

        // TRNG user filtering and lock
        write_reg("trng valid user", make_addr(1, 16), 32'h5a, 8'h33);
        for (int i = 0; i < NUM_TRNG; i++)
            write_reg("trng bad user", make_addr(1, i), $urandom, 8'h11);
        for (int i = 0; i < NUM_TRNG; i++) read_check("trng after bad", make_addr(1, i), 0);
        for (int i = 0; i < NUM_TRNG; i++)
            write_reg("trng good user", make_addr(1, i), $urandom, 8'h5a);
        for (int i = 0; i < NUM_TRNG; i++) read_check("trng after good", make_addr(1, i), 1);
        write_reg("trng done bad", make_addr(1, 18), 32'd1, 8'h11);
        check_value("trng_done_o bad", {31'd0, m_trng_done}, {31'd0, trng_done_o});
        write_reg("trng done good", make_addr(1, 18), 32'd1, 8'h5a);
        check_value("trng_done_o good", {31'd0, m_trng_done}, {31'd0, trng_done_o});
        read_check("trng status", make_addr(1, 18), 0);
        write_reg("trng lock", make_addr(1, 17), 32'd1, 8'h5a);
        write_reg("trng user locked", make_addr(1, 16), 32'h77, 8'h5a);
        read_check("trng valid user", make_addr(1, 16), 0);
        read_check("trng lock", make_addr(1, 17), 0);
        read_check("trng unmapped", make_addr(1, 25), 2);

        // Boot sequence finishes on its own
        cnt = 0;
        while (!uc_rst_b_o && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (!uc_rst_b_o) report_problem("Timeout waiting for uc_rst_b_o to rise");
        repeat (2) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tests/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic cptra_rst_b
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cptra_rst_b = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 cptra_rst_b = 1'b1;
    end

endmodule

//--- verilog.f
source/soc_ifc_map_pkg.sv
source/soc_ifc_boot_pkg.sv
source/soc_req_slave.sv
source/fuse_regs.sv
source/trng_regs.sv
source/boot_fsm.sv
source/soc_ifc_top.sv
tests/tb_clk_gen.sv
tests/soc_ifc_tb.sv
